/* hw/enc_cfg_pkg.sv */
// Datapath sizes shared by the encoder source, frame buffer and sink
// Referenced by scoped names from every RTL file of the encoder
package enc_cfg_pkg;

  // ------------------------------
  // Word and symbol widths
  // ------------------------------

  // Buffered data word
  localparam int WORD_W = 16;
  // Output symbol (nibble)
  localparam int NIB_W = 4;
  // Symbols per word for the width converter
  localparam int DWC_FACTOR = WORD_W / NIB_W;
  localparam int DWC_CNT_W = 2;

  // Frame tag carried from input to output
  localparam int TAG_W = 4;

  // ------------------------------
  // Buffer geometry
  // ------------------------------

  localparam int BUF_DEPTH = 16;
  // One extra bit so a full 16-word size is representable
  localparam int ADDR_W = 5;
  // Last slot is kept for the parity word
  localparam int MAX_DATA_WORDS = BUF_DEPTH - 1;

endpackage

/* hw/enc_ctrl_pkg.sv */
// State encodings for the encoder control machines
// Source and sink each pick their own type by scoped name
package enc_ctrl_pkg;

  // ------------------------------
  // Source FSM
  // ------------------------------

  // Idle, data load, parity write, wait for drain
  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    LOAD   = 2'd1,
    PARITY = 2'd2,
    HOLD   = 2'd3
  } src_state_t;

  // ------------------------------
  // Sink FSM
  // ------------------------------

  typedef enum logic {
    WAIT_FULL = 1'b0,
    DRAIN     = 1'b1
  } sink_state_t;

endpackage

/* hw/enc_source.sv */
// Input side of the encoder: writes one frame of words into the buffer
// and appends the running XOR of the data as a closing parity word
module enc_source (
  input  logic                             iclk,
  input  logic                             ireset,
  input  logic                             iclkena,
  input  logic                             isop,
  input  logic                             ival,
  input  logic                             ieop,
  input  logic [enc_cfg_pkg::WORD_W-1:0]   idat,
  input  logic [enc_cfg_pkg::TAG_W-1:0]    itag,
  input  logic                             buf_empty,
  output logic                             obusy,
  output logic                             wr_en,
  output logic [enc_cfg_pkg::ADDR_W-1:0]   wr_addr,
  output logic [enc_cfg_pkg::WORD_W-1:0]   wr_dat,
  output logic                             wr_done,
  output logic [enc_cfg_pkg::ADDR_W-1:0]   wr_size,
  output logic [enc_cfg_pkg::TAG_W-1:0]    wr_tag
);

  enc_ctrl_pkg::src_state_t state;

  // Data word count, also the next write address
  logic [enc_cfg_pkg::ADDR_W-1:0] cnt;
  // Parity accumulator and latched tag
  logic [enc_cfg_pkg::WORD_W-1:0] acc;
  logic [enc_cfg_pkg::TAG_W-1:0]  tag;
  logic                           load_word;

  // ------------------------------
  // Write port
  // ------------------------------

  // First word only with isop, later words in LOAD
  assign load_word = ival & ((state == enc_ctrl_pkg::LOAD) |
                             ((state == enc_ctrl_pkg::IDLE) & isop));

  assign wr_en   = load_word | (state == enc_ctrl_pkg::PARITY);
  assign wr_addr = (state == enc_ctrl_pkg::IDLE) ? '0 : cnt;
  // Parity goes right after the last data word
  assign wr_dat  = (state == enc_ctrl_pkg::PARITY) ? acc : idat;
  assign wr_done = (state == enc_ctrl_pkg::PARITY);
  assign wr_size = cnt + enc_cfg_pkg::ADDR_W'(1);
  assign wr_tag  = tag;

  // Busy from parity write until the sink has drained the frame
  assign obusy = (state == enc_ctrl_pkg::PARITY) | (state == enc_ctrl_pkg::HOLD);

  // ------------------------------
  // FSM and counter
  // ------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state <= enc_ctrl_pkg::IDLE;
      cnt   <= '0;
    end else if (iclkena) begin
      case (state)
        enc_ctrl_pkg::IDLE: begin
          if (load_word) begin
            cnt   <= enc_cfg_pkg::ADDR_W'(1);
            // Single-word frame goes straight to parity
            state <= ieop ? enc_ctrl_pkg::PARITY : enc_ctrl_pkg::LOAD;
          end
        end
        enc_ctrl_pkg::LOAD: begin
          if (load_word) begin
            cnt <= cnt + enc_cfg_pkg::ADDR_W'(1);
            if (ieop) begin
              state <= enc_ctrl_pkg::PARITY;
            end
          end
        end
        enc_ctrl_pkg::PARITY: state <= enc_ctrl_pkg::HOLD;
        default: begin
          if (buf_empty) begin
            state <= enc_ctrl_pkg::IDLE;
          end
        end
      endcase
    end
  end

  // Accumulator restarts from the first word of each frame
  always_ff @(posedge iclk) begin
    if (iclkena & load_word) begin
      acc <= (state == enc_ctrl_pkg::IDLE) ? idat : (acc ^ idat);
      if (state == enc_ctrl_pkg::IDLE) begin
        tag <= itag;
      end
    end
  end

  // Upstream must respect the busy level
  a_no_val_busy : assert property (@(posedge iclk) disable iff (ireset)
    iclkena & ival |-> !obusy);

  a_sop_idle : assert property (@(posedge iclk) disable iff (ireset)
    iclkena & isop |-> state == enc_ctrl_pkg::IDLE);

  a_cnt_max : assert property (@(posedge iclk) disable iff (ireset)
    cnt <= enc_cfg_pkg::ADDR_W'(enc_cfg_pkg::MAX_DATA_WORDS));

endmodule

/* hw/enc_frame_buf.sv */
// Single-frame word store between encoder source and sink
// Holds frame size, tag and a full flag handed over from writer to reader
module enc_frame_buf (
  input  logic                             iclk,
  input  logic                             ireset,
  input  logic                             iclkena,
  input  logic                             wr_en,
  input  logic [enc_cfg_pkg::ADDR_W-1:0]   wr_addr,
  input  logic [enc_cfg_pkg::WORD_W-1:0]   wr_dat,
  input  logic                             wr_done,
  input  logic [enc_cfg_pkg::ADDR_W-1:0]   wr_size,
  input  logic [enc_cfg_pkg::TAG_W-1:0]    wr_tag,
  input  logic [enc_cfg_pkg::ADDR_W-1:0]   buf_raddr,
  input  logic                             buf_empty,
  output logic                             buf_full,
  output logic [enc_cfg_pkg::WORD_W-1:0]   buf_rdat,
  output logic [enc_cfg_pkg::ADDR_W-1:0]   buf_size,
  output logic [enc_cfg_pkg::TAG_W-1:0]    buf_tag
);

  logic [enc_cfg_pkg::WORD_W-1:0] mem [enc_cfg_pkg::BUF_DEPTH];

  // ------------------------------
  // Memory
  // ------------------------------

  // Top address bit only matters for the size, not for indexing
  always_ff @(posedge iclk) begin
    if (iclkena) begin
      if (wr_en) begin
        mem[wr_addr[enc_cfg_pkg::ADDR_W-2:0]] <= wr_dat;
      end
      // Registered read, data one cycle after the address
      buf_rdat <= mem[buf_raddr[enc_cfg_pkg::ADDR_W-2:0]];
    end
  end

  // Frame descriptor
  always_ff @(posedge iclk) begin
    if (iclkena & wr_done) begin
      buf_size <= wr_size;
      buf_tag  <= wr_tag;
    end
  end

  // ------------------------------
  // Full flag
  // ------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      buf_full <= 1'b0;
    end else if (iclkena) begin
      if (wr_done) begin
        buf_full <= 1'b1;
      end else if (buf_empty) begin
        buf_full <= 1'b0;
      end
    end
  end

  // Source must wait for the drain before closing a new frame
  a_done_not_full : assert property (@(posedge iclk) disable iff (ireset)
    iclkena & wr_done |-> !buf_full);

endmodule

/* hw/enc_sink.sv */
// Output side of the encoder: drains the buffered frame on request and
// converts 16-bit words to nibbles, lsb first, with sop, eop and tag
module enc_sink (
  input  logic                             iclk,
  input  logic                             ireset,
  input  logic                             iclkena,
  input  logic [enc_cfg_pkg::ADDR_W-1:0]   buf_size,
  input  logic                             buf_full,
  input  logic [enc_cfg_pkg::WORD_W-1:0]   buf_rdat,
  input  logic [enc_cfg_pkg::TAG_W-1:0]    buf_tag,
  input  logic                             ireq,
  output logic                             buf_empty,
  output logic [enc_cfg_pkg::ADDR_W-1:0]   buf_raddr,
  output logic                             ofull,
  output logic                             osop,
  output logic                             oeop,
  output logic                             oval,
  output logic [enc_cfg_pkg::NIB_W-1:0]    odat,
  output logic [enc_cfg_pkg::TAG_W-1:0]    otag
);

  enc_ctrl_pkg::sink_state_t state;

  // Symbol counter within a word
  logic [enc_cfg_pkg::DWC_CNT_W-1:0] sym_cnt;
  logic                              sym_done;
  logic                              sym_zero;
  // Word counter within the frame
  logic [enc_cfg_pkg::ADDR_W-1:0]    word_cnt;
  logic                              word_done;

  // Three-stage pipe to match the buffer read latency
  logic [2:0]                        val;
  logic [2:0]                        eop;
  logic [1:0]                        rval;
  logic [1:0]                        set_sf;
  logic [enc_cfg_pkg::WORD_W-1:0]    rdat;

  logic                              work_done;
  logic                              start;
  logic                              take;

  assign work_done = sym_done & word_done;
  assign start     = (state == enc_ctrl_pkg::WAIT_FULL) & buf_full;
  // A request accepted during drain
  assign take      = (state == enc_ctrl_pkg::DRAIN) & ireq;

  // Last request of the frame releases the buffer
  assign buf_empty = take & work_done;
  assign buf_raddr = word_cnt;

  // ------------------------------
  // FSM and counters
  // ------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state     <= enc_ctrl_pkg::WAIT_FULL;
      sym_cnt   <= '0;
      sym_done  <= 1'b0;
      sym_zero  <= 1'b1;
      word_cnt  <= '0;
      word_done <= 1'b0;
    end else if (iclkena) begin
      if (state == enc_ctrl_pkg::WAIT_FULL) begin
        state     <= buf_full ? enc_ctrl_pkg::DRAIN : enc_ctrl_pkg::WAIT_FULL;
        sym_cnt   <= '0;
        sym_done  <= 1'b0;
        sym_zero  <= 1'b1;
        word_cnt  <= '0;
        word_done <= 1'b0;
      end else if (ireq) begin
        if (work_done) begin
          state <= enc_ctrl_pkg::WAIT_FULL;
        end
        sym_cnt  <= sym_done ? '0 : (sym_cnt + 1'b1);
        sym_done <= (sym_cnt == enc_cfg_pkg::DWC_CNT_W'(enc_cfg_pkg::DWC_FACTOR - 2));
        sym_zero <= sym_done;
        // Word counter steps after the last symbol of a word
        if (sym_done) begin
          word_cnt  <= word_done ? '0 : (word_cnt + 1'b1);
          word_done <= (word_cnt == buf_size - enc_cfg_pkg::ADDR_W'(2));
        end
      end
    end
  end

  // ------------------------------
  // Strobes and frame marks
  // ------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      val    <= '0;
      eop    <= '0;
      rval   <= '0;
      set_sf <= '0;
      ofull  <= 1'b0;
      osop   <= 1'b0;
    end else if (iclkena) begin
      val    <= {val[1:0], take};
      eop    <= {eop[1:0], take & work_done};
      // Word load marker for the first symbol of each word
      rval   <= {rval[0], take & sym_zero};
      set_sf <= {set_sf[0], start};
      if (set_sf[1]) begin
        ofull <= 1'b1;
      end else if (oeop) begin
        ofull <= 1'b0;
      end
      // sop stays up until the first symbol has gone out
      if (set_sf[1]) begin
        osop <= 1'b1;
      end else if (oval) begin
        osop <= 1'b0;
      end
    end
  end

  assign oval = val[2];
  assign oeop = eop[2];

  // ------------------------------
  // Width converter
  // ------------------------------

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      if (val[1]) begin
        rdat <= rval[1] ? buf_rdat : (rdat >> enc_cfg_pkg::NIB_W);
      end
      if (start) begin
        otag <= buf_tag;
      end
    end
  end

  // Least significant nibble leaves first
  assign odat = rdat[enc_cfg_pkg::NIB_W-1:0];

  a_val_in_full : assert property (@(posedge iclk) disable iff (ireset)
    oval |-> ofull);

endmodule

/* hw/enc_top.sv */
// Encoder output end: frame source, single-frame buffer and nibble sink
// Upstream honours obusy, downstream pulls symbols with ireq
module enc_top (
  input  logic                             iclk,
  input  logic                             ireset,
  input  logic                             iclkena,
  input  logic                             isop,
  input  logic                             ival,
  input  logic                             ieop,
  input  logic [enc_cfg_pkg::WORD_W-1:0]   idat,
  input  logic [enc_cfg_pkg::TAG_W-1:0]    itag,
  input  logic                             ireq,
  output logic                             obusy,
  output logic                             ofull,
  output logic                             osop,
  output logic                             oeop,
  output logic                             oval,
  output logic [enc_cfg_pkg::NIB_W-1:0]    odat,
  output logic [enc_cfg_pkg::TAG_W-1:0]    otag
);

  // ------------------------------
  // Source to buffer
  // ------------------------------

  logic                           wr_en;
  logic [enc_cfg_pkg::ADDR_W-1:0] wr_addr;
  logic [enc_cfg_pkg::WORD_W-1:0] wr_dat;
  logic                           wr_done;
  logic [enc_cfg_pkg::ADDR_W-1:0] wr_size;
  logic [enc_cfg_pkg::TAG_W-1:0]  wr_tag;

  // Buffer and sink handshake
  logic                           buf_full;
  logic                           buf_empty;
  logic [enc_cfg_pkg::ADDR_W-1:0] buf_raddr;
  logic [enc_cfg_pkg::WORD_W-1:0] buf_rdat;
  logic [enc_cfg_pkg::ADDR_W-1:0] buf_size;
  logic [enc_cfg_pkg::TAG_W-1:0]  buf_tag;

  enc_source source0 (
    .iclk      (iclk),
    .ireset    (ireset),
    .iclkena   (iclkena),
    .isop      (isop),
    .ival      (ival),
    .ieop      (ieop),
    .idat      (idat),
    .itag      (itag),
    .buf_empty (buf_empty),
    .obusy     (obusy),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_dat    (wr_dat),
    .wr_done   (wr_done),
    .wr_size   (wr_size),
    .wr_tag    (wr_tag)
  );

  enc_frame_buf buf0 (
    .iclk      (iclk),
    .ireset    (ireset),
    .iclkena   (iclkena),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_dat    (wr_dat),
    .wr_done   (wr_done),
    .wr_size   (wr_size),
    .wr_tag    (wr_tag),
    .buf_raddr (buf_raddr),
    .buf_empty (buf_empty),
    .buf_full  (buf_full),
    .buf_rdat  (buf_rdat),
    .buf_size  (buf_size),
    .buf_tag   (buf_tag)
  );

  enc_sink sink0 (
    .iclk      (iclk),
    .ireset    (ireset),
    .iclkena   (iclkena),
    .buf_size  (buf_size),
    .buf_full  (buf_full),
    .buf_rdat  (buf_rdat),
    .buf_tag   (buf_tag),
    .ireq      (ireq),
    .buf_empty (buf_empty),
    .buf_raddr (buf_raddr),
    .ofull     (ofull),
    .osop      (osop),
    .oeop      (oeop),
    .oval      (oval),
    .odat      (odat),
    .otag      (otag)
  );

endmodule

/* bench/enc_tb.sv */
// Testbench for the encoder output end
// Reads frames from the stimulus file and checks the nibble stream of enc_top
module enc_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [31:0] SEED = 32'h08638dec;

  logic        iclk = 1'b0;
  logic        ireset = 1'b1;
  logic        iclkena = 1'b1;
  logic        isop = 1'b0;
  logic        ival = 1'b0;
  logic        ieop = 1'b0;
  logic [15:0] idat = '0;
  logic [3:0]  itag = '0;
  logic        ireq = 1'b0;
  logic        obusy;
  logic        ofull;
  logic        osop;
  logic        oeop;
  logic        oval;
  logic [3:0]  odat;
  logic [3:0]  otag;

  // Frame table from the stimulus file
  int unsigned fr_mode[$];
  int unsigned fr_tag[$];
  int unsigned fr_cnt[$];
  int unsigned fr_base[$];
  // Data words of all frames back to back
  int unsigned words[$];
  int unsigned tok_q[$];
  // Expected symbols packed as tag, sop, eop, nibble
  logic [9:0]  exp_q[$];
  logic [9:0]  exp_e;
  logic [2:0]  req_hist = '0;
  logic        prev_ena = 1'b1;
  logic        last_oval = 1'b0;
  logic [3:0]  last_odat = '0;
  bit          gaps = 0;
  bit          rnd_req = 0;
  bit          loaded = 0;
  int          errors = 0;
  int          symbols = 0;
  longint      limit_ns;

  enc_top dut0 (.*);

  always #5 iclk = ~iclk;

  function automatic int hex_digit(input byte c);
    if (c >= "0" && c <= "9") return int'(c - "0");
    if (c >= "a" && c <= "f") return int'(c - "a") + 10;
    if (c >= "A" && c <= "F") return int'(c - "A") + 10;
    return -1;
  endfunction

  // Splits a line into hex tokens
  function automatic void split_hex(input string s);
    int unsigned v;
    bit          have;
    int          d;
    int          i;
    tok_q.delete();
    v = 0;
    have = 0;
    for (i = 0; i < s.len(); i++) begin
      d = hex_digit(s[i]);
      if (d >= 0) begin
        v = (v << 4) | d;
        have = 1;
      end else begin
        if (have) tok_q.push_back(v);
        v = 0;
        have = 0;
      end
    end
    if (have) tok_q.push_back(v);
  endfunction

  // Four nibbles per word with the lsb nibble first
  function automatic void push_word(input logic [15:0] w, input logic [3:0] tag,
                                    input bit first, input bit last);
    int k;
    for (k = 0; k < 4; k++) begin
      exp_q.push_back({tag, first && k == 0, last && k == 3, w[4*k +: 4]});
    end
  endfunction

  // Next falling edge with fresh enable and request levels
  task automatic cycle();
    @(negedge iclk);
    iclkena = gaps ? (($urandom % 4) != 0) : 1'b1;
    ireq = rnd_req ? 1'($urandom % 2) : 1'b1;
  endtask

  task automatic drive_frame(input int base, input int cnt, input logic [3:0] tag);
    int          i;
    logic [15:0] w;
    logic [15:0] par;
    par = '0;
    for (i = 0; i < cnt; i++) begin
      w = 16'(words[base + i]);
      par = par ^ w;
      // Hold the word until an enabled edge takes it
      do begin
        cycle();
        isop = (i == 0);
        ival = 1'b1;
        ieop = (i == cnt - 1);
        idat = w;
        itag = tag;
      end while (!iclkena);
      push_word(w, tag, i == 0, 0);
    end
    cycle();
    isop = 1'b0;
    ival = 1'b0;
    ieop = 1'b0;
    push_word(par, tag, 0, 1);
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) cycle();
    assert (!ofull) else begin
      $display("** Error at %0t: ofull still high after the last symbol", $time);
      errors++;
    end
  endtask

  // Reset in the middle of a frame
  task automatic mid_reset();
    @(negedge iclk);
    ireset = 1'b1;
    iclkena = 1'b1;
    ireq = 1'b0;
    repeat (2) @(negedge iclk);
    assert (!obusy && !ofull && !osop && !oval && !oeop) else begin
      $display("** Error at %0t: control outputs not low during reset", $time);
      errors++;
    end
    exp_q.delete();
    repeat (3) @(negedge iclk);
    ireset = 1'b0;
  endtask

  // ------------------------------
  // Output monitor
  // ------------------------------

  always @(posedge iclk) begin
    if (ireset) begin
      req_hist = '0;
      prev_ena = 1'b1;
    end else begin
      // Disabled edge must leave the outputs alone
      if (!prev_ena) begin
        assert (oval == last_oval && odat == last_odat) else begin
          $display("** Error at %0t: output changed while clock enable was low", $time);
          errors++;
        end
      end
      if (iclkena && oval) begin
        symbols++;
        assert (req_hist[2]) else begin
          $display("** Error at %0t: symbol without a request three cycles before", $time);
          errors++;
        end
        assert (exp_q.size() != 0) else begin
          $display("** Error at %0t: symbol %h seen with none expected", $time, odat);
          errors++;
        end
        if (exp_q.size() != 0) begin
          exp_e = exp_q.pop_front();
          assert ({otag, osop, oeop, odat} == exp_e) else begin
            $display("** Error at %0t: expected tag %h sop %b eop %b nib %h, seen %h %b %b %h",
                     $time, exp_e[9:6], exp_e[5], exp_e[4], exp_e[3:0],
                     otag, osop, oeop, odat);
            errors++;
          end
        end
      end
      if (iclkena) req_hist = {req_hist[1:0], ireq};
      prev_ena = iclkena;
    end
    last_oval = oval;
    last_odat = odat;
  end

  // ------------------------------
  // Watchdog
  // ------------------------------

  initial begin
    wait (loaded);
    #(limit_ns * 1ns);
    $display("Timeout: the run did not finish within %0d ns", limit_ns);
    $display("test failed");
    $finish;
  end

  // ------------------------------
  // Main sequence
  // ------------------------------

  initial begin
    int          fd;
    string       line;
    int          f;
    int          mode;
    int          err_before;
    int          n_ok;
    bit          pending;
    longint      n_sym;
    void'($urandom(SEED));
    n_ok = 0;
    pending = 0;
    n_sym = 0;
    fd = $fopen("bench/enc_tb_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file bench/enc_tb_input.txt");
      $display("test failed");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        if ($fgets(line, fd) && line.len() > 0 && line[0] != "#") begin
          split_hex(line);
          if (tok_q.size() >= 3 && tok_q[2] >= 1 && tok_q[2] <= 15 &&
              tok_q.size() >= tok_q[2] + 3) begin
            fr_mode.push_back(tok_q[0]);
            fr_tag.push_back(tok_q[1]);
            fr_cnt.push_back(tok_q[2]);
            fr_base.push_back(words.size());
            for (int i = 0; i < int'(tok_q[2]); i++) words.push_back(tok_q[i + 3]);
            n_sym += (tok_q[2] + 1) * 4;
          end else if (tok_q.size() != 0) begin
            $display("Malformed frame line in the stimulus file: %s", line);
            errors++;
          end
        end
      end
      $fclose(fd);
      // Fixed cost per frame plus a worst-case rate per symbol
      limit_ns = fr_mode.size() * 600 + n_sym * 40 + 2000;
      loaded = 1;
      repeat (5) @(negedge iclk);
      ireset = 1'b0;
      for (f = 0; f < fr_mode.size(); f++) begin
        mode = fr_mode[f];
        err_before = errors;
        gaps = (mode == 2);
        rnd_req = (mode == 1 || mode == 2);
        if (mode == 4) wait_drain();
        cycle();
        while (obusy) cycle();
        // Previous frame may only have its last symbols in flight
        if (pending) begin
          assert (exp_q.size() <= 3) else begin
            $display("obusy fell with %0d symbols of the previous frame left", exp_q.size());
            errors++;
          end
          pending = 0;
        end
        drive_frame(fr_base[f], fr_cnt[f], 4'(fr_tag[f]));
        if (mode == 4) begin
          // Reset once about half the symbols have left
          while (exp_q.size() > (fr_cnt[f] + 1) * 2) cycle();
          mid_reset();
        end else if (mode == 3) begin
          pending = 1;
        end else begin
          wait_drain();
        end
        if (errors == err_before) n_ok++;
        $display("frame %0d: mode %0d, tag %h, %0d words, %s", f, mode, fr_tag[f],
                 fr_cnt[f], (errors == err_before) ? "ok" : "mismatch");
      end
      gaps = 0;
      rnd_req = 0;
      wait_drain();
      $display("%0d frames, %0d ok, %0d with errors, %0d symbols, %0d check failures",
               fr_mode.size(), n_ok, fr_mode.size() - n_ok, symbols, errors);
      if (errors == 0) begin
        $display("test passed");
      end else begin
        $display("test failed");
      end
      $finish;
    end
  end

endmodule

/* bench/enc_tb_input.txt */
# mode tag count words, all hex; mode 0 ireq high, 1 random ireq, 2 random ireq and
# enable gaps, 3 next frame back-to-back, 4 reset after half the words
0 3 1 a5c3
0 7 f 1234 5678 9abc def0 0f1e 2d3c 4b5a 6978 8796 a5b4 c3d2 e1f0 1357 2468 ffff
1 2 f 0001 0010 0100 1000 f00f 0ff0 aaaa 5555 3c3c c3c3 7e81 817e dead beef cafe
1 9 3 4321 8765 cba9
2 4 f 1111 2222 3333 4444 5555 6666 7777 8888 9999 aaaa bbbb cccc dddd eeee 0000
2 b 2 fedc ba98
3 1 2 0a0b 0c0d
3 2 1 7777
3 5 f 9e37 79b9 7f4a 7c15 f39c c060 5ced c834 1082 276b f58f 4ed3 a1b2 c3d4 e5f6
0 c 4 abcd 1234 fedc 5678
4 d 6 1010 2020 3030 4040 5050 6060
0 e 5 0123 4567 89ab cdef 0f0f
1 f 1 8001
2 6 7 1f2e 3d4c 5b6a 7988 97a6 b5c4 d3e2
3 8 3 aaaa bbbb cccc
3 a 2 0101 1010
0 0 f 8421 4218 2184 1842 fff0 0fff f0f0 0f0f 1357 9bdf 2468 ace0 0000 ffff 5a5a

/* filelist.f */
hw/enc_cfg_pkg.sv
hw/enc_ctrl_pkg.sv
hw/enc_source.sv
hw/enc_frame_buf.sv
hw/enc_sink.sv
hw/enc_top.sv
bench/enc_tb.sv

/* Makefile */
# Verilator build and run for the encoder testbench

VERILATOR ?= verilator
TOP       ?= enc_tb
RTL_TOP   ?= enc_top
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= test passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal
JOBS      ?= 4

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
